/* design/rv_pkg.sv */
package rv_pkg;

	typedef logic [31:0] word_t;     // data, address or instruction
	typedef logic [4:0]  reg_idx_t;

	// major opcodes kept by this core
	typedef enum logic [6:0] {
		op     = 7'b0110011,
		op_imm = 7'b0010011,
		load   = 7'b0000011,
		store  = 7'b0100011,
		lui    = 7'b0110111
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_op_e;

	typedef enum logic [2:0] {
		st_fetch,
		st_decode,
		st_execute,
		st_memory,
		st_writeback
	} state_e;

	localparam word_t reset_pc = 32'h0000_0000;
	localparam word_t pc_step  = 32'd4;

	// apb pprot, bit 2 marks an instruction access
	localparam logic [2:0] pprot_instr = 3'b100;
	localparam logic [2:0] pprot_data  = 3'b000;

endpackage

/* design/rv_decoder.sv */
module rv_decoder (
	input  rv_pkg::word_t    instr,
	output rv_pkg::opcode_e  opc,
	output rv_pkg::reg_idx_t rd,
	output rv_pkg::reg_idx_t rs1,
	output rv_pkg::reg_idx_t rs2,
	output rv_pkg::word_t    imm,
	output rv_pkg::alu_op_e  alu_op
);

	logic [2:0] funct3;
	logic [6:0] funct7;    // imm[11:5] for immediate shifts

	assign opc    = rv_pkg::opcode_e'(instr[6:0]);
	assign rd     = instr[11:7];
	assign funct3 = instr[14:12];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign funct7 = instr[31:25];

	always_comb begin
		case (opc)
			rv_pkg::op_imm,
			rv_pkg::load:
				imm = {{20{instr[31]}}, instr[31:20]};                // I format
			rv_pkg::store:
				imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};   // S format
			rv_pkg::lui:
				imm = {instr[31:12], 12'b0};                          // U format
			default:
				imm = '0;
		endcase
	end

	always_comb begin
		alu_op = rv_pkg::alu_add;    // also the load/store address add
		if (opc == rv_pkg::op || opc == rv_pkg::op_imm) begin
			case (funct3)
				3'b000: begin
					// only the register form has sub
					if (opc == rv_pkg::op && funct7[5])
						alu_op = rv_pkg::alu_sub;
					else
						alu_op = rv_pkg::alu_add;
				end
				3'b001:
					alu_op = rv_pkg::alu_sll;
				3'b010:
					alu_op = rv_pkg::alu_slt;
				3'b011:
					alu_op = rv_pkg::alu_sltu;
				3'b100:
					alu_op = rv_pkg::alu_xor;
				3'b101: begin
					if (funct7[5])
						alu_op = rv_pkg::alu_sra;
					else
						alu_op = rv_pkg::alu_srl;
				end
				3'b110:
					alu_op = rv_pkg::alu_or;
				default:
					alu_op = rv_pkg::alu_and;
			endcase
		end
	end

endmodule

/* design/rv_alu.sv */
module rv_alu (
	input  rv_pkg::word_t   a,
	input  rv_pkg::word_t   b,
	input  rv_pkg::alu_op_e alu_op,
	output rv_pkg::word_t   y
);

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (alu_op)
			rv_pkg::alu_add:
				y = a + b;
			rv_pkg::alu_sub:
				y = a - b;
			rv_pkg::alu_sll:
				y = a << shamt;
			rv_pkg::alu_slt:
				y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			rv_pkg::alu_sltu:
				y = (a < b) ? 32'd1 : 32'd0;
			rv_pkg::alu_xor:
				y = a ^ b;
			rv_pkg::alu_srl:
				y = a >> shamt;
			rv_pkg::alu_sra:
				y = $signed(a) >>> shamt;    // keeps the sign bit
			rv_pkg::alu_or:
				y = a | b;
			rv_pkg::alu_and:
				y = a & b;
			default:
				y = '0;
		endcase
	end

endmodule

/* design/rv_regfile.sv */
module rv_regfile (
	input  logic             clk,
	input  logic             rst,
	input  rv_pkg::reg_idx_t rs1,
	input  rv_pkg::reg_idx_t rs2,
	input  rv_pkg::reg_idx_t rd,
	input  logic             we,
	input  rv_pkg::word_t    wdata,
	output rv_pkg::word_t    rs1_data,
	output rv_pkg::word_t    rs2_data
);

	rv_pkg::word_t regs [1:31];    // x0 has no storage

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (we && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* design/rv_apb_master.sv */
module rv_apb_master (
	input  logic          clk,
	input  logic          rst,
	input  logic          bus_req,
	input  logic          bus_write,
	input  logic          bus_instr,
	input  rv_pkg::word_t bus_addr,
	input  rv_pkg::word_t bus_wdata,
	output logic          bus_done,
	output rv_pkg::word_t bus_rdata,
	output rv_pkg::word_t paddr,
	output rv_pkg::word_t pwdata,
	output logic          psel,
	output logic          penable,
	output logic          pwrite,
	output logic [2:0]    pprot,
	input  rv_pkg::word_t prdata,
	input  logic          pready
);

	logic start;

	// idle is !psel, setup is psel && !penable, access is psel && penable
	assign start = bus_req && !psel;

	always_ff @(posedge clk) begin
		if (rst) begin
			psel    <= 1'b0;
			penable <= 1'b0;
			pwrite  <= 1'b0;
		end else if (start) begin
			psel   <= 1'b1;
			pwrite <= bus_write;
		end else if (psel && !penable) begin
			penable <= 1'b1;
		end else if (psel && pready) begin
			psel    <= 1'b0;    // back to idle
			penable <= 1'b0;
			pwrite  <= 1'b0;
		end
	end

	// held for the whole transfer
	always_ff @(posedge clk) begin
		if (start) begin
			paddr  <= bus_addr;
			pwdata <= bus_wdata;
			pprot  <= bus_instr ? rv_pkg::pprot_instr : rv_pkg::pprot_data;
		end
	end

	assign bus_done  = psel && penable && pready;
	assign bus_rdata = prdata;

endmodule

/* design/rv_core_ctrl.sv */
module rv_core_ctrl (
	input  logic             clk,
	input  logic             rst,
	output rv_pkg::word_t    instr,
	input  rv_pkg::opcode_e  opc,
	input  rv_pkg::reg_idx_t rd,
	input  rv_pkg::word_t    imm,
	input  rv_pkg::word_t    rs1_data,
	input  rv_pkg::word_t    rs2_data,
	input  rv_pkg::word_t    alu_y,
	output rv_pkg::word_t    alu_b,
	output logic             rf_we,
	output rv_pkg::word_t    rf_wdata,
	output logic             bus_req,
	output logic             bus_write,
	output logic             bus_instr,
	output rv_pkg::word_t    bus_addr,
	output rv_pkg::word_t    bus_wdata,
	input  logic             bus_done,
	input  rv_pkg::word_t    bus_rdata
);

	rv_pkg::state_e state;
	rv_pkg::word_t  pc;
	rv_pkg::word_t  result;
	rv_pkg::word_t  fetch_addr;
	logic           boot;        // first pass after reset, no instruction yet
	logic           is_mem;
	logic           writes_rd;
	logic           fetch_go;
	logic           data_go;

	assign is_mem    = (opc == rv_pkg::load) || (opc == rv_pkg::store);
	assign writes_rd = (opc == rv_pkg::op) || (opc == rv_pkg::op_imm) ||
	                   (opc == rv_pkg::lui) || (opc == rv_pkg::load);

	// reset enters writeback so the first fetch setup lines up like any other
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= rv_pkg::st_writeback;
			boot  <= 1'b1;
			pc    <= rv_pkg::reset_pc;
		end else begin
			case (state)
				rv_pkg::st_fetch: begin
					if (bus_done) begin
						instr <= bus_rdata;
						state <= rv_pkg::st_decode;
					end
				end
				rv_pkg::st_decode:
					state <= rv_pkg::st_execute;    // decoder and reg reads settle
				rv_pkg::st_execute: begin
					result <= (opc == rv_pkg::lui) ? imm : alu_y;
					state  <= rv_pkg::st_memory;
				end
				rv_pkg::st_memory: begin
					if (!is_mem || bus_done) begin
						if (opc == rv_pkg::load)
							result <= bus_rdata;
						state <= rv_pkg::st_writeback;
					end
				end
				rv_pkg::st_writeback: begin
					if (!boot)
						pc <= pc + rv_pkg::pc_step;
					boot  <= 1'b0;
					state <= rv_pkg::st_fetch;
				end
				default:
					state <= rv_pkg::st_fetch;
			endcase
		end
	end

	// register form takes rs2, everything else the immediate
	assign alu_b = (opc == rv_pkg::op) ? rs2_data : imm;

	// requests go out one cycle ahead so the setup phase opens the next step
	assign fetch_go   = (state == rv_pkg::st_writeback);
	assign data_go    = (state == rv_pkg::st_execute) && is_mem;
	assign fetch_addr = boot ? pc : pc + rv_pkg::pc_step;

	assign bus_req   = fetch_go || data_go;
	assign bus_instr = fetch_go;
	assign bus_write = data_go && (opc == rv_pkg::store);
	assign bus_addr  = fetch_go ? fetch_addr : rs1_data + imm;    // lw and sw address
	assign bus_wdata = rs2_data;

	// store and illegal opcodes retire without a write
	assign rf_we    = fetch_go && !boot && writes_rd && (rd != '0);
	assign rf_wdata = result;

endmodule

/* design/rv_core_top.sv */
module rv_core_top (
	input  logic          clk,
	input  logic          rst,
	output rv_pkg::word_t paddr,
	output rv_pkg::word_t pwdata,
	output logic          psel,
	output logic          penable,
	output logic          pwrite,
	output logic [2:0]    pprot,
	input  rv_pkg::word_t prdata,
	input  logic          pready
);

	rv_pkg::word_t    instr;
	rv_pkg::opcode_e  opc;
	rv_pkg::reg_idx_t rd;
	rv_pkg::reg_idx_t rs1;
	rv_pkg::reg_idx_t rs2;
	rv_pkg::word_t    imm;
	rv_pkg::alu_op_e  alu_op;
	rv_pkg::word_t    rs1_data;
	rv_pkg::word_t    rs2_data;
	rv_pkg::word_t    alu_b;
	rv_pkg::word_t    alu_y;
	logic             rf_we;
	rv_pkg::word_t    rf_wdata;
	logic             bus_req;
	logic             bus_write;
	logic             bus_instr;
	rv_pkg::word_t    bus_addr;
	rv_pkg::word_t    bus_wdata;
	logic             bus_done;
	rv_pkg::word_t    bus_rdata;

	rv_core_ctrl rv_core_ctrl_inst (
		.clk       (clk),
		.rst       (rst),
		.instr     (instr),
		.opc       (opc),
		.rd        (rd),
		.imm       (imm),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.alu_y     (alu_y),
		.alu_b     (alu_b),
		.rf_we     (rf_we),
		.rf_wdata  (rf_wdata),
		.bus_req   (bus_req),
		.bus_write (bus_write),
		.bus_instr (bus_instr),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.bus_done  (bus_done),
		.bus_rdata (bus_rdata)
	);

	rv_decoder rv_decoder_inst (
		.instr  (instr),
		.opc    (opc),
		.rd     (rd),
		.rs1    (rs1),
		.rs2    (rs2),
		.imm    (imm),
		.alu_op (alu_op)
	);

	rv_alu rv_alu_inst (
		.a      (rs1_data),
		.b      (alu_b),
		.alu_op (alu_op),
		.y      (alu_y)
	);

	rv_regfile rv_regfile_inst (
		.clk      (clk),
		.rst      (rst),
		.rs1      (rs1),
		.rs2      (rs2),
		.rd       (rd),
		.we       (rf_we),
		.wdata    (rf_wdata),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	rv_apb_master rv_apb_master_inst (
		.clk       (clk),
		.rst       (rst),
		.bus_req   (bus_req),
		.bus_write (bus_write),
		.bus_instr (bus_instr),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.bus_done  (bus_done),
		.bus_rdata (bus_rdata),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.pprot     (pprot),
		.prdata    (prdata),
		.pready    (pready)
	);

endmodule

/* tb/rv_core_asserts.sv */
module rv_core_asserts (
	input logic          clk,
	input logic          rst,
	input logic          psel,
	input logic          penable,
	input logic          pwrite,
	input logic          pready,
	input rv_pkg::word_t paddr,
	input rv_pkg::word_t pwdata
);

	timeunit 1ns;
	timeprecision 100ps;

	enable_needs_sel: assert property (@(posedge clk) disable iff (rst)
		penable |-> psel)
		else $error("penable without psel");

	setup_then_access: assert property (@(posedge clk) disable iff (rst)
		(psel && !penable) |=> (psel && penable))
		else $error("setup not followed by access");

	// request fields hold until pready
	fields_stable: assert property (@(posedge clk) disable iff (rst)
		(psel && !pready) |=> ($stable(paddr) && $stable(pwrite) && $stable(pwdata)))
		else $error("apb fields changed mid transfer");

	idle_after_reset: assert property (@(posedge clk)
		rst |=> !psel)
		else $error("psel high after reset");

endmodule

/* tb/rv_core_tb.sv */
module rv_core_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int prog_len   = 200;
	localparam int tail_len   = 31;     // one sw per register at the end
	localparam int fetch_goal = prog_len + tail_len + 1;
	localparam int run_limit  = 8000;

	logic          clk;
	logic          rst;
	rv_pkg::word_t paddr;
	rv_pkg::word_t pwdata;
	logic          psel;
	logic          penable;
	logic          pwrite;
	logic [2:0]    pprot;
	rv_pkg::word_t prdata;
	logic          pready;

	rv_pkg::word_t imem [256];
	rv_pkg::word_t dmem [256];    // slave side
	rv_pkg::word_t mdata [256];   // model side
	rv_pkg::word_t mregs [32];
	rv_pkg::word_t model_pc;
	rv_pkg::word_t exp_addr;
	rv_pkg::word_t exp_data;
	logic          exp_store;
	logic          exp_load;
	integer        seed;
	int            wait_cnt;
	int            fetch_count;
	int            cycles;

	rv_core_top rv_core_top_inst (
		.clk     (clk),
		.rst     (rst),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pprot   (pprot),
		.prdata  (prdata),
		.pready  (pready)
	);

	bind rv_apb_master rv_core_asserts rv_core_asserts_inst (.*);

	always #2 clk = ~clk;

	function automatic rv_pkg::alu_op_e pick_op(logic [2:0] f3, logic alt, logic is_reg);
		case (f3)
			3'd0: return (is_reg && alt) ? rv_pkg::alu_sub : rv_pkg::alu_add;
			3'd1: return rv_pkg::alu_sll;
			3'd2: return rv_pkg::alu_slt;
			3'd3: return rv_pkg::alu_sltu;
			3'd4: return rv_pkg::alu_xor;
			3'd5: return alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
			3'd6: return rv_pkg::alu_or;
			default: return rv_pkg::alu_and;
		endcase
	endfunction

	// expected alu result
	function automatic rv_pkg::word_t alu_ref(rv_pkg::alu_op_e op, rv_pkg::word_t a,
			rv_pkg::word_t b);
		case (op)
			rv_pkg::alu_add:  return a + b;
			rv_pkg::alu_sub:  return a - b;
			rv_pkg::alu_sll:  return a << b[4:0];
			rv_pkg::alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			rv_pkg::alu_sltu: return (a < b) ? 32'd1 : 32'd0;
			rv_pkg::alu_xor:  return a ^ b;
			rv_pkg::alu_srl:  return a >> b[4:0];
			rv_pkg::alu_sra:  return rv_pkg::word_t'($signed(a) >>> b[4:0]);
			rv_pkg::alu_or:   return a | b;
			default:          return a & b;
		endcase
	endfunction

	function automatic rv_pkg::word_t enc_i(logic [11:0] imm, rv_pkg::reg_idx_t rs1,
			logic [2:0] f3, rv_pkg::reg_idx_t rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic rv_pkg::word_t enc_s(logic [11:0] imm, rv_pkg::reg_idx_t rs2,
			rv_pkg::reg_idx_t rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	task automatic report_mismatch(string msg);
		$display("CHECK FAILED at %0t: %s", $time, msg);
		$display("TEST FAIL");
		$fatal(1, "mismatch");
	endtask

	task automatic check_fetch(rv_pkg::word_t addr);
		if (addr !== model_pc)
			report_mismatch($sformatf("fetch at %h, expected %h", addr, model_pc));
		if (pwrite !== 1'b0)
			report_mismatch("fetch drives pwrite high");
		if (pprot !== rv_pkg::pprot_instr)
			report_mismatch($sformatf("fetch pprot %b, expected %b", pprot,
				rv_pkg::pprot_instr));
		if (exp_store || exp_load)
			report_mismatch("next fetch before the data transfer");
	endtask

	task automatic check_store(rv_pkg::word_t addr, rv_pkg::word_t data);
		if (!exp_store || pwrite !== 1'b1)
			report_mismatch("unexpected write transfer");
		if (pprot !== rv_pkg::pprot_data)
			report_mismatch($sformatf("store pprot %b, expected %b", pprot,
				rv_pkg::pprot_data));
		if (addr !== exp_addr || data !== exp_data)
			report_mismatch($sformatf("store %h=%h, expected %h=%h",
				addr, data, exp_addr, exp_data));
	endtask

	task automatic check_load_addr(rv_pkg::word_t addr);
		if (!exp_load || pwrite !== 1'b0)
			report_mismatch("unexpected read transfer");
		if (pprot !== rv_pkg::pprot_data)
			report_mismatch($sformatf("load pprot %b, expected %b", pprot,
				rv_pkg::pprot_data));
		if (addr !== exp_addr)
			report_mismatch($sformatf("load at %h, expected %h", addr, exp_addr));
	endtask

	task automatic retire_model(rv_pkg::word_t ins);
		rv_pkg::reg_idx_t rd;
		rv_pkg::word_t    r1;
		rv_pkg::word_t    r2;
		rv_pkg::word_t    imm_i;
		rv_pkg::word_t    res;
		logic             wr;
		rd    = ins[11:7];
		r1    = mregs[ins[19:15]];
		r2    = mregs[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		wr    = 1'b1;
		res   = '0;
		case (ins[6:0])
			rv_pkg::op:
				res = alu_ref(pick_op(ins[14:12], ins[30], 1'b1), r1, r2);
			rv_pkg::op_imm:
				res = alu_ref(pick_op(ins[14:12], ins[30], 1'b0), r1, imm_i);
			rv_pkg::lui:
				res = {ins[31:12], 12'b0};
			rv_pkg::load: begin
				exp_addr = r1 + imm_i;
				exp_load = 1'b1;
				res      = mdata[exp_addr[9:2]];
			end
			rv_pkg::store: begin
				exp_addr  = r1 + {{20{ins[31]}}, ins[31:25], ins[11:7]};
				exp_data  = r2;
				exp_store = 1'b1;
				mdata[exp_addr[9:2]] = r2;
				wr = 1'b0;
			end
			default:
				wr = 1'b0;    // illegal, no-op
		endcase
		if (wr && rd != 0)
			mregs[rd] = res;
	endtask

	task automatic build_program();
		int                r;
		logic [2:0]        f3;
		logic [11:0]       imm;
		rv_pkg::reg_idx_t  rd;
		rv_pkg::reg_idx_t  rs1;
		rv_pkg::reg_idx_t  rs2;
		for (int i = 0; i < 256; i++)
			imem[i] = enc_i(12'd0, 5'd0, 3'd0, 5'd0, rv_pkg::op_imm);    // nop
		for (int i = 0; i < prog_len; i++) begin
			r   = $unsigned($random(seed)) % 40;
			f3  = 3'($random(seed));
			imm = 12'($random(seed));
			rd  = 5'($random(seed));
			rs1 = 5'($random(seed));
			rs2 = 5'($random(seed));
			if (r < 8)
				imem[i] = enc_s(imm, rs2, rs1);
			else if (r < 13)
				imem[i] = enc_i(imm, rs1, 3'b010, rd, rv_pkg::load);
			else if (r < 16)
				imem[i] = {imm, rs2, 3'b000, rd, rv_pkg::lui};
			else if (r < 28)
				imem[i] = {(f3 == 0 || f3 == 5) && imm[0] ? 7'h20 : 7'h00,
					rs2, rs1, f3, rd, rv_pkg::op};
			else begin
				if (f3 == 1)
					imm[11:5] = 7'h00;
				else if (f3 == 5)
					imm[11:5] = imm[0] ? 7'h20 : 7'h00;
				imem[i] = enc_i(imm, rs1, f3, rd, rv_pkg::op_imm);
			end
		end
		for (int k = 1; k <= tail_len; k++)
			imem[prog_len + k - 1] = enc_s(12'(k * 4), 5'(k), 5'd0);
	endtask

	// apb slave
	always @(posedge clk) begin
		#0.5;
		if (rst) begin
			pready = 1'b0;
		end else if (psel && !penable) begin
			wait_cnt = $unsigned($random(seed)) % 4;    // wait cycles in the access phase
			pready   = 1'b0;
			if (pprot[2]) begin
				prdata = imem[paddr[9:2]];
			end else begin
				prdata = dmem[paddr[9:2]];
				if (pwrite)
					dmem[paddr[9:2]] = pwdata;
			end
		end else if (psel && penable && !pready) begin
			if (wait_cnt == 0)
				pready = 1'b1;
			else
				wait_cnt--;
		end else begin
			pready = 1'b0;
		end
	end

	// setup phases, sampled at the edge
	always @(posedge clk) begin
		if (!rst && psel && !penable) begin
			if (pprot[2]) begin
				check_fetch(paddr);
				retire_model(imem[model_pc[9:2]]);
				model_pc = model_pc + rv_pkg::pc_step;
				fetch_count++;
			end else if (pwrite) begin
				check_store(paddr, pwdata);
				exp_store = 1'b0;
			end else begin
				check_load_addr(paddr);
				exp_load = 1'b0;
			end
		end
	end

	initial begin
		clk         = 1'b0;
		rst         = 1'b1;
		prdata      = '0;
		pready      = 1'b0;
		seed        = 32'h4af7dd27;
		model_pc    = rv_pkg::reset_pc;
		exp_store   = 1'b0;
		exp_load    = 1'b0;
		exp_addr    = '0;
		exp_data    = '0;
		fetch_count = 0;
		for (int i = 0; i < 32; i++)
			mregs[i] = '0;
		for (int i = 0; i < 256; i++) begin
			dmem[i]  = $random(seed);
			mdata[i] = dmem[i];
		end
		build_program();
		repeat (16) @(posedge clk);
		#0.5 rst = 1'b0;
		cycles = 0;
		while (fetch_count < fetch_goal && cycles < run_limit) begin
			@(posedge clk);
			cycles++;
		end
		if (fetch_count < fetch_goal) begin
			$display("timeout: the core stopped fetching after %0d instructions", fetch_count);
			$display("TEST FAIL");
			$fatal(1, "timeout");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

/* rv_core.f */
design/rv_pkg.sv
design/rv_decoder.sv
design/rv_alu.sv
design/rv_regfile.sv
design/rv_apb_master.sv
design/rv_core_ctrl.sv
design/rv_core_top.sv
tb/rv_core_asserts.sv
tb/rv_core_tb.sv

/* Makefile */
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = rv_core_tb
FILELIST   = rv_core.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
